//--- exePkg.sv
`default_nettype none

package exePkg;

    typedef logic [31:0] dataT;   // data word
    typedef logic [4:0]  regIdxT; // register index
    typedef logic [4:0]  shamtT;  // shift amount

    typedef enum logic [4:0] {
        NOP,
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI,
        MFHI,
        MFLO,
        MTHI,
        MTLO,
        MULT,
        MULTU,
        DIV,
        DIVU
    } aluOpE;

    // destination register source
    typedef enum logic [1:0] {
        RD,
        RT,
        R31
    } dstSelE;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } mduStateE;

    // operands already resolved by bypass in ID
    typedef struct packed {
        dataT   busA;
        dataT   busB;
        dataT   imm;
        shamtT  shamt;
        regIdxT rt;
        regIdxT rd;
        aluOpE  aluOp;
        dstSelE dstSel;
        logic   srcAShamt; // A <= zero-extended shamt
        logic   srcBImm;   // B <= imm
        logic   regWr;
    } idExeT;

    typedef struct packed {
        dataT   result;
        regIdxT dst;
        logic   regWr;
        logic   overflow;
    } exeMemT;

endpackage

`default_nettype wire

//--- exeReg.sv
`timescale 1ns/1ps
`default_nettype none

module exeReg (
    input  logic          clk,
    input  logic          rstN,
    input  logic          exeWr,
    input  logic          exeFlush,
    input  logic          mduStall,
    input  exePkg::idExeT idIn,
    output exePkg::idExeT cur
);

    import exePkg::*;

    logic isMdOp;

    assign isMdOp = cur.aluOp inside {MULT, MULTU, DIV, DIVU};

    // all-zero bundle is a bubble: NOP with regWr low
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cur <= '0;
        end else if (exeFlush) begin
            cur <= '0;           // flush wins over write
        end else if (exeWr) begin
            cur <= idIn;
        end
    end

    // hazard unit must hold the stage while the MDU is running
    noWrDuringMdu: assert property (
        @(posedge clk) disable iff (!rstN)
        !(exeWr && mduStall && isMdOp)
    ) else $error("exeWr high while multiply/divide stalls the stage");

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exePkg::dataT  a,
    input  exePkg::dataT  b,
    input  exePkg::dataT  hi,
    input  exePkg::dataT  lo,
    input  exePkg::shamtT shamt,
    input  exePkg::aluOpE aluOp,
    output exePkg::dataT  result,
    output logic          overflow
);

    import exePkg::*;

    dataT sum;
    dataT diff;
    logic addOvf;
    logic subOvf;
    logic lessS;
    logic lessU;

    assign sum  = a + b;
    assign diff = a - b;

    // signed wrap: operands agree in sign and the result does not
    assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

    assign lessS = $signed(a) < $signed(b);
    assign lessU = a < b;

    always_comb begin
        result = '0;
        case (aluOp)
            ADD, ADDU: result = sum;
            SUB, SUBU: result = diff;
            AND:       result = a & b;
            OR:        result = a | b;
            XOR:       result = a ^ b;
            NOR:       result = ~(a | b);
            SLT:       result = {31'b0, lessS};
            SLTU:      result = {31'b0, lessU};
            SLL:       result = b << shamt;
            SRL:       result = b >> shamt;
            SRA:       result = $signed(b) >>> shamt;
            LUI:       result = {b[15:0], 16'b0};
            MFHI:      result = hi;
            MFLO:      result = lo;
            default:   result = '0; // NOP, MTHI/MTLO and MDU ops
        endcase
    end

    always_comb begin
        case (aluOp)
            ADD:     overflow = addOvf;
            SUB:     overflow = subOvf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- mduCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module mduCtrl (
    input  logic          clk,
    input  logic          rstN,
    input  logic          exeWr,
    input  logic          exeFlush,
    input  logic          lastStep,
    input  exePkg::aluOpE aluOp,
    output logic          load,
    output logic          step,
    output logic          doneP,
    output logic          mduStall
);

    import exePkg::*;

    mduStateE state;
    mduStateE nextState;
    logic     isMdOp;

    assign isMdOp = aluOp inside {MULT, MULTU, DIV, DIVU};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        load      = 1'b0;
        step      = 1'b0;
        doneP     = 1'b0;
        mduStall  = 1'b0;
        case (state)
            IDLE: begin
                if (isMdOp) begin
                    mduStall = 1'b1;
                    if (!exeFlush) begin
                        load      = 1'b1;
                        nextState = BUSY;
                    end
                end
            end
            BUSY: begin
                step     = 1'b1;
                mduStall = 1'b1;
                if (exeFlush) begin
                    nextState = IDLE; // abort leaves HI/LO untouched
                end else if (lastStep) begin
                    doneP     = 1'b1; // HI/LO written at this edge
                    nextState = DONE;
                end
            end
            DONE: begin
                // wait for the op to leave so it is not restarted
                if (exeWr || exeFlush) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    // the counter has to give exactly 32 steps per operation
    noEarlyDone: assert property (
        @(posedge clk) disable iff (!rstN)
        load |=> (!doneP) [*31]
    ) else $error("doneP before the 32nd step");

    doneOnTime: assert property (
        @(posedge clk) disable iff (!rstN)
        load ##1 (!exeFlush) [*32] |-> doneP
    ) else $error("doneP missing after 32 steps");

endmodule

`default_nettype wire

//--- mduCounter.sv
`timescale 1ns/1ps
`default_nettype none

module mduCounter (
    input  logic clk,
    input  logic rstN,
    input  logic load,
    input  logic step,
    output logic lastStep
);

    logic [4:0] count;

    // 32 steps: 31 down to 0
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= 5'd31;
        end else if (step) begin
            count <= count - 5'd1;
        end
    end

    assign lastStep = step && (count == 5'd0);

endmodule

`default_nettype wire

//--- mduDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module mduDatapath (
    input  logic          clk,
    input  logic          rstN,
    input  logic          load,
    input  logic          step,
    input  exePkg::dataT  a,
    input  exePkg::dataT  b,
    input  exePkg::aluOpE aluOp,
    output exePkg::dataT  hiRes,
    output exePkg::dataT  loRes
);

    import exePkg::*;

    logic        signedOp;
    logic        isDivOp;
    dataT        magA;
    dataT        magB;
    logic        isDiv;
    logic        negLo;     // product or quotient sign
    logic        negHi;     // remainder follows dividend
    logic [63:0] acc;       // mul {partial, multiplier}, div {rem, quot}
    dataT        opB;       // multiplicand or divisor magnitude
    logic [32:0] addSum;
    logic [32:0] subDiff;
    logic [63:0] accNext;
    logic [63:0] prod;
    dataT        quot;
    dataT        rem;

    assign signedOp = aluOp inside {MULT, DIV};
    assign isDivOp  = aluOp inside {DIV, DIVU};
    assign magA     = (signedOp && a[31]) ? -a : a;
    assign magB     = (signedOp && b[31]) ? -b : b;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            isDiv <= 1'b0;
            negLo <= 1'b0;
            negHi <= 1'b0;
        end else if (load) begin
            isDiv <= isDivOp;
            negLo <= signedOp & (a[31] ^ b[31]);
            negHi <= signedOp & a[31];
        end
    end

    // low half starts as multiplier or dividend, the same word either way
    always_ff @(posedge clk) begin
        if (load) begin
            acc <= {32'b0, magA};
            opB <= magB;
        end else if (step) begin
            acc <= accNext;
        end
    end

    assign addSum  = {1'b0, acc[63:32]} + {1'b0, opB};
    assign subDiff = acc[63:31] - {1'b0, opB};

    always_comb begin
        if (isDiv) begin
            // restoring: keep the shifted remainder on borrow
            if (subDiff[32]) begin
                accNext = {acc[62:0], 1'b0};
            end else begin
                accNext = {subDiff[31:0], acc[30:0], 1'b1};
            end
        end else begin
            accNext = acc[0] ? {addSum, acc[31:1]} : {1'b0, acc[63:1]};
        end
    end

    // taken from accNext so the final step is included when doneP fires
    assign prod = negLo ? -accNext : accNext;
    assign quot = negLo ? -accNext[31:0] : accNext[31:0];
    assign rem  = negHi ? -accNext[63:32] : accNext[63:32];

    assign hiRes = isDiv ? rem : prod[63:32];
    assign loRes = isDiv ? quot : prod[31:0];

endmodule

`default_nettype wire

//--- hiLo.sv
`timescale 1ns/1ps
`default_nettype none

module hiLo (
    input  logic         clk,
    input  logic         rstN,
    input  logic         hiWr,
    input  logic         loWr,
    input  logic         doneP,
    input  exePkg::dataT wrData,
    input  exePkg::dataT hiRes,
    input  exePkg::dataT loRes,
    output exePkg::dataT hi,
    output exePkg::dataT lo
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (doneP) begin
            hi <= hiRes;         // finished mul/div owns both
            lo <= loRes;
        end else begin
            if (hiWr) begin
                hi <= wrData;
            end
            if (loWr) begin
                lo <= wrData;
            end
        end
    end

endmodule

`default_nettype wire

//--- exeStage.sv
`timescale 1ns/1ps
`default_nettype none

module exeStage (
    input  logic           clk,
    input  logic           rstN,
    input  logic           exeWr,
    input  logic           exeFlush,
    input  exePkg::idExeT  idIn,
    output exePkg::exeMemT exeOut,
    output logic           mduStall
);

    import exePkg::*;

    idExeT  cur;
    dataT   opA;
    dataT   opB;
    dataT   aluRes;
    logic   overflow;
    dataT   hi;
    dataT   lo;
    logic   load;
    logic   step;
    logic   doneP;
    logic   lastStep;
    dataT   hiRes;
    dataT   loRes;
    logic   hiWr;
    logic   loWr;
    regIdxT dst;

    exeReg u_exeReg (
        .clk      (clk),
        .rstN     (rstN),
        .exeWr    (exeWr),
        .exeFlush (exeFlush),
        .mduStall (mduStall),
        .idIn     (idIn),
        .cur      (cur)
    );

    assign opA = cur.srcAShamt ? {27'b0, cur.shamt} : cur.busA;
    assign opB = cur.srcBImm ? cur.imm : cur.busB;

    alu u_alu (
        .a        (opA),
        .b        (opB),
        .hi       (hi),
        .lo       (lo),
        .shamt    (opA[4:0]),  // amount from low bits of A
        .aluOp    (cur.aluOp),
        .result   (aluRes),
        .overflow (overflow)
    );

    mduCtrl u_mduCtrl (
        .clk      (clk),
        .rstN     (rstN),
        .exeWr    (exeWr),
        .exeFlush (exeFlush),
        .lastStep (lastStep),
        .aluOp    (cur.aluOp),
        .load     (load),
        .step     (step),
        .doneP    (doneP),
        .mduStall (mduStall)
    );

    mduCounter u_mduCounter (
        .clk      (clk),
        .rstN     (rstN),
        .load     (load),
        .step     (step),
        .lastStep (lastStep)
    );

    mduDatapath u_mduDatapath (
        .clk   (clk),
        .rstN  (rstN),
        .load  (load),
        .step  (step),
        .a     (cur.busA),
        .b     (cur.busB),
        .aluOp (cur.aluOp),
        .hiRes (hiRes),
        .loRes (loRes)
    );

    assign hiWr = (cur.aluOp == MTHI);
    assign loWr = (cur.aluOp == MTLO);

    hiLo u_hiLo (
        .clk    (clk),
        .rstN   (rstN),
        .hiWr   (hiWr),
        .loWr   (loWr),
        .doneP  (doneP),
        .wrData (cur.busA),
        .hiRes  (hiRes),
        .loRes  (loRes),
        .hi     (hi),
        .lo     (lo)
    );

    always_comb begin
        case (cur.dstSel)
            RT:      dst = cur.rt;
            R31:     dst = 5'd31;  // link register
            default: dst = cur.rd;
        endcase
    end

    assign exeOut.result   = aluRes;
    assign exeOut.dst      = dst;
    assign exeOut.regWr    = cur.regWr & ~overflow; // no writeback on overflow
    assign exeOut.overflow = overflow;

endmodule

`default_nettype wire

//--- tbExeStage.sv
`timescale 1ns/1ps
`default_nettype none

module tbExeStage;

    import exePkg::*;

    localparam int RandOps = 40;

    logic   clk;
    logic   rstN;
    logic   exeWr;
    logic   exeFlush;
    idExeT  idIn;
    exeMemT exeOut;
    logic   mduStall;

    int     dataErrs;
    int     dstErrs;
    int     flagErrs;
    int     otherErrs;
    int     cycles;
    int     cycleLimit;
    integer seed;
    string  lines[$];   // vector lines without comments

    exeStage u_exeStage (
        .clk      (clk),
        .rstN     (rstN),
        .exeWr    (exeWr),
        .exeFlush (exeFlush),
        .idIn     (idIn),
        .exeOut   (exeOut),
        .mduStall (mduStall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hard stop if the stage never lets go
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic checkData(input string what, input dataT got, input dataT exp);
        if (got !== exp) begin
            dataErrs++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkDst(input string what, input regIdxT got, input regIdxT exp);
        if (got !== exp) begin
            dstErrs++;
            $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            flagErrs++;
            $display("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic idExeT makeOp(input aluOpE op, input dataT a, input dataT b,
                                     input dataT imm, input shamtT sh, input regIdxT rt,
                                     input regIdxT rd, input dstSelE sel,
                                     input logic [1:0] src, input logic wr);
        idExeT v;
        v.busA      = a;
        v.busB      = b;
        v.imm       = imm;
        v.shamt     = sh;
        v.rt        = rt;
        v.rd        = rd;
        v.aluOp     = op;
        v.dstSel    = sel;
        v.srcAShamt = src[1];
        v.srcBImm   = src[0];
        v.regWr     = wr;
        return v;
    endfunction

    task automatic lookupOp(input string name, output aluOpE op, output logic found);
        aluOpE e;
        found = 1'b0;
        op    = NOP;
        e     = e.first();
        repeat (e.num()) begin
            if (e.name() == name) begin
                op    = e;
                found = 1'b1;
            end
            e = e.next();
        end
    endtask

    // called at a falling edge, returns at the next one with the op in the stage
    task automatic applyOp(input idExeT op);
        idIn  = op;
        exeWr = 1'b1;
        @(negedge clk);
    endtask

    // hold the stage while the multiply/divide unit runs
    task automatic waitMdu(output int n);
        n = 0;
        while (mduStall) begin
            exeWr = 1'b0;
            n++;
            @(negedge clk);
        end
    endtask

    task automatic runVector(input string line);
        string opName;
        string resTok;
        aluOpE op;
        logic  known;
        dataT  a, b, imm, expRes;
        int    sh, rt, rd, sel, src, wr;
        int    expDst, expWr, expOvf;
        int    fields;
        int    stall;
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %s %h %h %h", opName, a, b,
                         imm, sh, rt, rd, sel, src, wr, resTok, expDst, expWr, expOvf);
        if (fields != 14) begin
            otherErrs++;
            $display("vector line could not be parsed: %s", line);
            return;
        end
        lookupOp(opName, op, known);
        if (!known) begin
            otherErrs++;
            $display("vector line names an unknown operation: %s", opName);
            return;
        end
        applyOp(makeOp(op, a, b, imm, shamtT'(sh), regIdxT'(rt), regIdxT'(rd),
                       dstSelE'(sel), src[1:0], wr[0]));
        if (resTok == "none") begin
            waitMdu(stall);
            if (op inside {MULT, MULTU, DIV, DIVU}) begin
                checkData($sformatf("%s stall cycles", opName), dataT'(stall), 32'd33);
            end
        end else begin
            void'($sscanf(resTok, "%h", expRes));
            checkData($sformatf("%s result", opName), exeOut.result, expRes);
            checkDst($sformatf("%s dst", opName), exeOut.dst, regIdxT'(expDst));
            checkFlag($sformatf("%s regWr", opName), exeOut.regWr, expWr[0]);
            checkFlag($sformatf("%s overflow", opName), exeOut.overflow, expOvf[0]);
        end
    endtask

    task automatic flushDuringDiv();
        applyOp(makeOp(MTHI, 32'h0badf00d, '0, '0, '0, '0, '0, RD, 2'b00, 1'b0));
        applyOp(makeOp(MTLO, 32'h600dcafe, '0, '0, '0, '0, '0, RD, 2'b00, 1'b0));
        applyOp(makeOp(DIV, 32'd100, 32'd7, '0, '0, '0, '0, RD, 2'b00, 1'b0));
        checkFlag("stall after DIV capture", mduStall, 1'b1);
        exeWr = 1'b0;
        repeat (5) @(negedge clk);
        checkFlag("stall mid DIV", mduStall, 1'b1);
        exeFlush = 1'b1;      // abort while BUSY
        @(negedge clk);
        exeFlush = 1'b0;
        checkFlag("stall after flush", mduStall, 1'b0);
        applyOp(makeOp(MFHI, '0, '0, '0, '0, '0, 5'd20, RD, 2'b00, 1'b1));
        checkData("HI after flushed DIV", exeOut.result, 32'h0badf00d);
        applyOp(makeOp(MFLO, '0, '0, '0, '0, '0, 5'd21, RD, 2'b00, 1'b1));
        checkData("LO after flushed DIV", exeOut.result, 32'h600dcafe);
    endtask

    task automatic runRandom();
        aluOpE  ops[5];
        aluOpE  op;
        dataT   a, b, expRes;
        regIdxT rd;
        ops = '{AND, OR, XOR, NOR, ADDU};
        repeat (RandOps) begin
            op = ops[$unsigned($random(seed)) % 5];
            a  = $random(seed);
            b  = $random(seed);
            rd = $random(seed);
            case (op)
                AND:     expRes = a & b;
                OR:      expRes = a | b;
                XOR:     expRes = a ^ b;
                NOR:     expRes = ~(a | b);
                default: expRes = a + b;   // ADDU wraps silently
            endcase
            applyOp(makeOp(op, a, b, '0, '0, '0, rd, RD, 2'b00, 1'b1));
            checkData($sformatf("random %s result", op.name()), exeOut.result, expRes);
            checkDst("random dst", exeOut.dst, rd);
            checkFlag("random regWr", exeOut.regWr, 1'b1);
            checkFlag("random overflow", exeOut.overflow, 1'b0);
        end
    endtask

    initial begin
        int    fd;
        string line;
        rstN      = 1'b0;
        exeWr     = 1'b0;
        exeFlush  = 1'b0;
        idIn      = '0;
        dataErrs  = 0;
        dstErrs   = 0;
        flagErrs  = 0;
        otherErrs = 0;
        cycles    = 0;
        seed      = 22;
        fd = $fopen("exeVectors.txt", "r");
        if (fd == 0) begin
            otherErrs++;
            $display("could not open exeVectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycleLimit = (lines.size() + RandOps) * 40;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        foreach (lines[i]) begin
            runVector(lines[i]);
        end
        flushDuringDiv();
        runRandom();
        exeWr = 1'b0;
        idIn  = '0;

        $display("errors: data %0d, dst %0d, flag %0d, other %0d",
                 dataErrs, dstErrs, flagErrs, otherErrs);
        if (dataErrs + dstErrs + flagErrs + otherErrs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exeVectors.txt
# op busA busB imm shamt rt rd dstSel(0 rd,1 rt,2 r31) src(2 shamt to A,1 imm to B) regWr
# then expected result (or none) dst regWr overflow; all numbers hex
ADDU  00000005 00000007 00000000 00 02 03 0 0 1 0000000c 03 1 0
ADD   7fffffff 00000001 00000000 00 02 04 0 0 1 80000000 04 0 1
ADDU  7fffffff 00000001 00000000 00 02 04 0 0 1 80000000 04 1 0
SUB   80000000 00000001 00000000 00 02 05 0 0 1 7fffffff 05 0 1
SUBU  80000000 00000001 00000000 00 02 05 0 0 1 7fffffff 05 1 0
ADD   00000010 00000000 fffffff0 00 06 07 1 1 1 00000000 06 1 0
AND   f0f0f0f0 ff00ff00 00000000 00 01 07 0 0 1 f000f000 07 1 0
OR    0f0f0000 000000ff 00000000 00 01 08 0 0 1 0f0f00ff 08 1 0
XOR   aaaaaaaa ffffffff 00000000 00 01 09 0 0 1 55555555 09 1 0
NOR   00000000 0000ffff 00000000 00 01 0a 0 0 1 ffff0000 0a 1 0
SLT   ffffffff 00000001 00000000 00 01 0b 0 0 1 00000001 0b 1 0
SLTU  ffffffff 00000001 00000000 00 01 0c 0 0 1 00000000 0c 1 0
SLL   00000000 00000001 00000000 1f 01 0d 0 2 1 80000000 0d 1 0
SRL   00000000 80000000 00000000 04 01 0e 0 2 1 08000000 0e 1 0
SRA   00000000 80000000 00000000 04 01 0f 0 2 1 f8000000 0f 1 0
SRA   00000024 f0000000 00000000 00 01 10 0 0 1 ff000000 10 1 0
LUI   00000000 00000000 00001234 00 11 12 1 1 1 12340000 11 1 0
OR    00000100 00000000 00000001 00 01 02 2 1 1 00000101 1f 1 0
MULT  fffffffd 00000007 00000000 00 00 00 0 0 0 none 00 0 0
MFHI  00000000 00000000 00000000 00 00 13 0 0 1 ffffffff 13 1 0
MFLO  00000000 00000000 00000000 00 00 14 0 0 1 ffffffeb 14 1 0
MULTU fffffffd 00000007 00000000 00 00 00 0 0 0 none 00 0 0
MFHI  00000000 00000000 00000000 00 00 13 0 0 1 00000006 13 1 0
MFLO  00000000 00000000 00000000 00 00 14 0 0 1 ffffffeb 14 1 0
DIV   ffffffeb 00000004 00000000 00 00 00 0 0 0 none 00 0 0
MFHI  00000000 00000000 00000000 00 00 13 0 0 1 ffffffff 13 1 0
MFLO  00000000 00000000 00000000 00 00 14 0 0 1 fffffffb 14 1 0
DIVU  ffffffeb 00000004 00000000 00 00 00 0 0 0 none 00 0 0
MFHI  00000000 00000000 00000000 00 00 13 0 0 1 00000003 13 1 0
MFLO  00000000 00000000 00000000 00 00 14 0 0 1 3ffffffa 14 1 0
MTHI  12345678 00000000 00000000 00 00 00 0 0 0 none 00 0 0
MTLO  9abcdef0 00000000 00000000 00 00 00 0 0 0 none 00 0 0
MFHI  00000000 00000000 00000000 00 00 15 0 0 1 12345678 15 1 0
MFLO  00000000 00000000 00000000 00 00 16 0 0 1 9abcdef0 16 1 0

//--- all.f
exePkg.sv
exeReg.sv
alu.sv
mduCtrl.sv
mduCounter.sv
mduDatapath.sv
hiLo.sv
exeStage.sv
tbExeStage.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  - exePkg.sv
  - exeReg.sv
  - alu.sv
  - mduCtrl.sv
  - mduCounter.sv
  - mduDatapath.sv
  - hiLo.sv
  - exeStage.sv
  - target: test
    files:
      - tbExeStage.sv
